/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // release on a falling edge, half a period clear of the next rising one
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #(PERIOD_NS / 2);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
  import rv_pkg::*;
();

  localparam int          PROG_LEN       = 400;
  localparam int          MEM_WORDS      = 512;
  localparam logic [31:0] RESET_PC       = 32'h0000_0400;
  localparam logic [31:0] SEED           = 32'h03b4_0ef3;
  localparam int          TIMEOUT_CYCLES = 2 * PROG_LEN + 50;

  logic                  clk;
  logic                  arst_n_i;
  logic                  fetch_en_i;
  logic [INST_W-1:0]     inst_i;
  logic [XLEN-1:0]       pc_o;
  logic                  wb_valid_o;
  logic [REG_ADDR_W-1:0] wb_rd_o;
  logic [XLEN-1:0]       wb_data_o;
  logic [XLEN-1:0]       retired_o;

  logic [31:0] imem [0:MEM_WORDS-1];
  logic [31:0] mem_off;
  logic [8:0]  mem_idx;
  logic [31:0] shadow [0:31];

  // expected results in fetch order, tagged with the fetch edge
  int          tag_q [$];
  logic [4:0]  rd_q [$];
  logic [31:0] data_q [$];

  // expected DUT outputs for the cycle in progress
  logic [31:0] exp_pc;
  logic        exp_wb_valid;
  logic [4:0]  exp_wb_rd;
  logic [31:0] exp_wb_data;
  logic [31:0] exp_retired;

  logic [31:0] cur_pc;
  int          edge_n;
  int          fetch_idx;
  int          retired_cnt;
  int          n_supported;
  int          tail;
  int          cycle_cnt = 0;
  logic        gen_ok;
  logic        m_ok;
  logic [4:0]  m_rd;
  logic [31:0] m_val;

  tb_clk_gen #(
    .PERIOD_NS  (20),
    .RST_CYCLES (2)
  ) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n_i)
  );

  rv_core_top #(
    .RESET_PC (RESET_PC)
  ) uut (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .fetch_en_i (fetch_en_i),
    .inst_i     (inst_i),
    .pc_o       (pc_o),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o),
    .wb_data_o  (wb_data_o),
    .retired_o  (retired_o)
  );

  // instruction memory, answers the current pc
  assign mem_off = pc_o - RESET_PC;
  assign mem_idx = mem_off[10:2];
  assign inst_i  = imem[mem_idx];

  // ==========================================================================
  // program generation and golden model
  // ==========================================================================
  task automatic gen_inst(output logic [31:0] inst, output logic ok);
    int unsigned kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    logic [11:0] imm;
    kind = $urandom_range(99);
    // x0..x5 only, keeps dependencies dense
    rd   = 5'($urandom_range(5));
    rs1  = 5'($urandom_range(5));
    rs2  = 5'($urandom_range(5));
    f3   = 3'($urandom);
    ok   = 1'b1;
    if (kind < 5) begin
      case ($urandom_range(4))
        0:       opc = 7'b000_0011;
        1:       opc = 7'b010_0011;
        2:       opc = 7'b110_0011;
        3:       opc = 7'b110_1111;
        default: opc = 7'b111_0011;
      endcase
      inst = {25'($urandom), opc};
      ok   = 1'b0;
    end else if (kind < 45) begin
      f7 = 7'h00;
      if (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom_range(1) == 1)) begin
        f7 = F7_ALT;
      end
      inst = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 80) begin
      imm = 12'($urandom);
      if (f3 == 3'd1) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'd5) begin
        imm[11:5] = ($urandom_range(1) == 1) ? F7_ALT : 7'h00;
      end
      inst = {imm, rs1, f3, rd, OPC_OP_IMM};
    end else if (kind < 90) begin
      inst = {20'($urandom), rd, OPC_LUI};
    end else begin
      inst = {20'($urandom), rd, OPC_AUIPC};
    end
  endtask

  function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0:    r = alt ? (a - b) : (a + b);
      3'd1:    r = a << b[4:0];
      3'd2:    r = {31'b0, $signed(a) < $signed(b)};
      3'd3:    r = {31'b0, a < b};
      3'd4:    r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // one instruction in program order against the shadow registers
  task automatic model_exec(input logic [31:0] inst, input logic [31:0] pc,
                            output logic ok, output logic [4:0] rd, output logic [31:0] val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    opc = inst[6:0];
    rd  = inst[11:7];
    f3  = inst[14:12];
    f7  = inst[31:25];
    imm = {{20{inst[31]}}, inst[31:20]};
    ok  = 1'b0;
    val = '0;
    case (opc)
      OPC_LUI: begin
        ok  = 1'b1;
        val = {inst[31:12], 12'h000};
      end
      OPC_AUIPC: begin
        ok  = 1'b1;
        val = pc + {inst[31:12], 12'h000};
      end
      OPC_OP: begin
        ok  = (f7 == 7'h00) || ((f7 == F7_ALT) && ((f3 == 3'd0) || (f3 == 3'd5)));
        val = int_op(f3, f7 == F7_ALT, shadow[inst[19:15]], shadow[inst[24:20]]);
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          ok = (f7 == 7'h00);
        end else if (f3 == 3'd5) begin
          ok = (f7 == 7'h00) || (f7 == F7_ALT);
        end else begin
          ok = 1'b1;
        end
        val = int_op(f3, (f3 == 3'd5) && (f7 == F7_ALT), shadow[inst[19:15]], imm);
      end
      default: ;
    endcase
    // x0 stays zero
    if (ok && (rd != 5'd0)) begin
      shadow[rd] = val;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "check failed on %s", name);
  endtask

  // ==========================================================================
  // checks
  // ==========================================================================
  a_reset_pc : assert property (
    @(posedge clk) $rose(arst_n_i) |-> pc_o == RESET_PC
  ) else report_mismatch("pc_o", RESET_PC, $sampled(pc_o));

  a_reset_idle : assert property (
    @(posedge clk) $rose(arst_n_i) |-> !wb_valid_o
  ) else report_mismatch("wb_valid_o", 32'h0, $sampled(wb_valid_o));

  a_reset_count : assert property (
    @(posedge clk) $rose(arst_n_i) |-> retired_o == '0
  ) else report_mismatch("retired_o", 32'h0, $sampled(retired_o));

  a_pc : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    pc_o == exp_pc
  ) else report_mismatch("pc_o", $sampled(exp_pc), $sampled(pc_o));

  a_wb_valid : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    wb_valid_o == exp_wb_valid
  ) else report_mismatch("wb_valid_o", $sampled(exp_wb_valid), $sampled(wb_valid_o));

  a_wb_rd : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    exp_wb_valid |-> wb_rd_o == exp_wb_rd
  ) else report_mismatch("wb_rd_o", $sampled(exp_wb_rd), $sampled(wb_rd_o));

  a_wb_data : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    exp_wb_valid |-> wb_data_o == exp_wb_data
  ) else report_mismatch("wb_data_o", $sampled(exp_wb_data), $sampled(wb_data_o));

  a_retired : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    retired_o == exp_retired
  ) else report_mismatch("retired_o", $sampled(exp_retired), $sampled(retired_o));

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    fetch_en_i   = 1'b0;
    exp_pc       = RESET_PC;
    exp_wb_valid = 1'b0;
    exp_wb_rd    = '0;
    exp_wb_data  = '0;
    exp_retired  = '0;
    cur_pc       = RESET_PC;
    edge_n       = 0;
    fetch_idx    = 0;
    retired_cnt  = 0;
    n_supported  = 0;
    tail         = 0;
    void'($urandom(SEED));
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    // program first, then unsupported words that carry their index
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < PROG_LEN) begin
        gen_inst(imem[i], gen_ok);
        if (gen_ok) begin
          n_supported++;
        end
      end else begin
        imem[i] = {25'(i), 7'b000_1011};
      end
    end

    wait (arst_n_i === 1'b1);
    while ((fetch_idx < PROG_LEN) || (tag_q.size() != 0) || (tail < 4)) begin
      @(posedge clk);
      #1;
      edge_n++;
      if ((fetch_idx == PROG_LEN) && (tag_q.size() == 0)) begin
        tail++;
      end

      // fetched at edge k, on the write-back port after edge k+2
      exp_pc      = cur_pc;
      exp_retired = 32'(retired_cnt);
      if ((tag_q.size() != 0) && (tag_q[0] == edge_n - 2)) begin
        exp_wb_valid = 1'b1;
        exp_wb_rd    = rd_q.pop_front();
        exp_wb_data  = data_q.pop_front();
        void'(tag_q.pop_front());
        retired_cnt++;
      end else begin
        exp_wb_valid = 1'b0;
      end

      // about one cycle in four is a bubble
      if ((fetch_idx < PROG_LEN) && ($urandom_range(3) != 0)) begin
        model_exec(imem[fetch_idx], cur_pc, m_ok, m_rd, m_val);
        if (m_ok) begin
          tag_q.push_back(edge_n + 1);
          rd_q.push_back(m_rd);
          data_q.push_back(m_val);
        end
        fetch_idx++;
        cur_pc     = cur_pc + 32'd4;
        fetch_en_i = 1'b1;
      end else begin
        fetch_en_i = 1'b0;
      end
    end

    if (retired_o !== 32'(n_supported)) begin
      report_mismatch("retired_o", 32'(n_supported), retired_o);
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core_top.sv
sim/tb_clk_gen.sv
sim/tb_rv_core.sv

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  alu_op_t         op_i,
  input  wire  [XLEN-1:0] a_i,
  input  wire  [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits shift
  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $signed(a_i) >>> shamt;
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      // lui
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // op comes from the decode register, which reset always defines
  always_comb begin
    a_op_known : assert final (!$isunknown(op_i))
      else $error("alu op_i unknown");
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import rv_pkg::*;
(
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire  [XLEN-1:0]       id_pc_i,
  input  wire  [INST_W-1:0]     id_inst_i,
  input  wire                   id_valid_i,
  input  wire                   wb_valid_i,
  input  wire  [REG_ADDR_W-1:0] wb_rd_i,
  input  wire  [XLEN-1:0]       wb_data_i,
  output logic [XLEN-1:0]       ex_pc_o,
  output logic [REG_ADDR_W-1:0] ex_rs1_o,
  output logic [REG_ADDR_W-1:0] ex_rs2_o,
  output logic [XLEN-1:0]       ex_rdata1_o,
  output logic [XLEN-1:0]       ex_rdata2_o,
  output logic [XLEN-1:0]       ex_imm_o,
  output logic [REG_ADDR_W-1:0] ex_rd_o,
  output alu_op_t               ex_alu_op_o,
  output logic                  ex_use_pc_o,
  output logic                  ex_use_imm_o,
  output logic                  ex_reg_write_o
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i_type;
  logic [XLEN-1:0]       imm_u_type;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;
  alu_op_t               alu_op;
  logic                  use_pc;
  logic                  use_imm;
  logic                  supported;

  // ==========================================================================
  // field split and immediates
  // ==========================================================================
  assign opcode = id_inst_i[6:0];
  assign rd     = id_inst_i[11:7];
  assign funct3 = id_inst_i[14:12];
  assign rs1    = id_inst_i[19:15];
  assign rs2    = id_inst_i[24:20];
  assign funct7 = id_inst_i[31:25];

  assign imm_i_type = {{(XLEN-12){id_inst_i[31]}}, id_inst_i[31:20]};
  assign imm_u_type = {id_inst_i[31:12], 12'b0};

  // funct3 to alu op, alt picks sub / sra
  function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    op = ALU_ADD;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  // control decode
  always_comb begin
    alu_op    = ALU_ADD;
    use_pc    = 1'b0;
    use_imm   = 1'b0;
    imm       = imm_i_type;
    supported = 1'b0;
    case (opcode)
      OPC_OP: begin
        supported = (funct7 == F7_BASE) ||
                    ((funct7 == F7_ALT) && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SR)));
        alu_op    = f3_to_op(funct3, funct7 == F7_ALT);
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          F3_SLL:  supported = (funct7 == F7_BASE);
          F3_SR:   supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          default: supported = 1'b1;
        endcase
        // no subi, alt only matters for the right shift
        alu_op = f3_to_op(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
      end
      OPC_LUI: begin
        supported = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_u_type;
        alu_op    = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        supported = 1'b1;
        use_pc    = 1'b1;
        use_imm   = 1'b1;
        imm       = imm_u_type;
      end
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .we_i     (wb_valid_i),
    .waddr_i  (wb_rd_i),
    .wdata_i  (wb_data_i),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  // ==========================================================================
  // decode to execute register
  // ==========================================================================
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_reg_write_o <= 1'b0;
      ex_alu_op_o    <= ALU_ADD;
      ex_use_pc_o    <= 1'b0;
      ex_use_imm_o   <= 1'b0;
    end else begin
      ex_reg_write_o <= id_valid_i && supported;
      ex_alu_op_o    <= alu_op;
      ex_use_pc_o    <= use_pc;
      ex_use_imm_o   <= use_imm;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc_o     <= id_pc_i;
    ex_rs1_o    <= rs1;
    ex_rs2_o    <= rs2;
    ex_rdata1_o <= rdata1;
    ex_rdata2_o <= rdata2;
    ex_imm_o    <= imm;
    ex_rd_o     <= rd;
  end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import rv_pkg::*;
(
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire  [XLEN-1:0]       ex_pc_i,
  input  wire  [REG_ADDR_W-1:0] ex_rs1_i,
  input  wire  [REG_ADDR_W-1:0] ex_rs2_i,
  input  wire  [XLEN-1:0]       ex_rdata1_i,
  input  wire  [XLEN-1:0]       ex_rdata2_i,
  input  wire  [XLEN-1:0]       ex_imm_i,
  input  wire  [REG_ADDR_W-1:0] ex_rd_i,
  input  alu_op_t               ex_alu_op_i,
  input  wire                   ex_use_pc_i,
  input  wire                   ex_use_imm_i,
  input  wire                   ex_reg_write_i,
  input  wire                   wb_valid_i,
  input  wire  [REG_ADDR_W-1:0] wb_rd_i,
  input  wire  [XLEN-1:0]       wb_data_i,
  output logic                  wb_reg_write_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_result_o
);

  logic            fwd_a;
  logic            fwd_b;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;

  // ==========================================================================
  // forwarding from write-back
  // ==========================================================================
  // the instruction one ahead is in write-back now, two ahead already
  // reached decode through the register file write-through
  assign fwd_a = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == ex_rs1_i);
  assign fwd_b = wb_valid_i && (wb_rd_i != '0) && (wb_rd_i == ex_rs2_i);

  assign rs1_val = fwd_a ? wb_data_i : ex_rdata1_i;
  assign rs2_val = fwd_b ? wb_data_i : ex_rdata2_i;

  // pc for auipc, immediate for op-imm / lui / auipc
  assign op_a = ex_use_pc_i  ? ex_pc_i  : rs1_val;
  assign op_b = ex_use_imm_i ? ex_imm_i : rs2_val;

  alu u_alu (
    .op_i     (ex_alu_op_i),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  // execute to write-back register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_reg_write_o <= 1'b0;
    end else begin
      wb_reg_write_o <= ex_reg_write_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o     <= ex_rd_i;
    wb_result_o <= alu_result;
  end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire                 clk,
  input  wire                 arst_n_i,
  input  wire                 fetch_en_i,
  input  wire  [INST_W-1:0]   inst_i,
  output logic [XLEN-1:0]     pc_o,
  output logic [XLEN-1:0]     id_pc_o,
  output logic [INST_W-1:0]   id_inst_o,
  output logic                id_valid_o
);

  // program counter, held while fetch is off
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o       <= RESET_PC;
      id_valid_o <= 1'b0;
    end else begin
      id_valid_o <= fetch_en_i;
      if (fetch_en_i) begin
        pc_o <= pc_o + XLEN'(4);
      end
    end
  end

  // fetch register, a disabled cycle turns into a nop bubble
  always_ff @(posedge clk) begin
    id_pc_o <= pc_o;
    if (fetch_en_i) begin
      id_inst_o <= inst_i;
    end else begin
      id_inst_o <= NOP_INST;
    end
  end

  // only +4 steps from an aligned reset value
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    pc_o[1:0] == 2'b00
  ) else $error("pc_o not word aligned: %h", pc_o);

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import rv_pkg::*;
(
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire  [REG_ADDR_W-1:0] raddr1_i,
  input  wire  [REG_ADDR_W-1:0] raddr2_i,
  input  wire                   we_i,
  input  wire  [REG_ADDR_W-1:0] waddr_i,
  input  wire  [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o
);

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];
  logic            wr_hit;

  assign wr_hit = we_i && (waddr_i != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // read ports with write-through
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else if (wr_hit && (waddr_i == raddr1_i)) begin
      rdata1_o = wdata_i;
    end else begin
      rdata1_o = regs[raddr1_i];
    end

    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else if (wr_hit && (waddr_i == raddr2_i)) begin
      rdata2_o = wdata_i;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire                   fetch_en_i,
  input  wire  [INST_W-1:0]     inst_i,
  output logic [XLEN-1:0]       pc_o,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic [XLEN-1:0]       retired_o
);

  // ==========================================================================
  // stage wiring
  // ==========================================================================
  logic [XLEN-1:0]       id_pc;
  logic [INST_W-1:0]     id_inst;
  logic                  id_valid;

  logic [XLEN-1:0]       ex_pc;
  logic [REG_ADDR_W-1:0] ex_rs1;
  logic [REG_ADDR_W-1:0] ex_rs2;
  logic [XLEN-1:0]       ex_rdata1;
  logic [XLEN-1:0]       ex_rdata2;
  logic [XLEN-1:0]       ex_imm;
  logic [REG_ADDR_W-1:0] ex_rd;
  alu_op_t               ex_alu_op;
  logic                  ex_use_pc;
  logic                  ex_use_imm;
  logic                  ex_reg_write;

  logic                  wb_reg_write;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_result;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .fetch_en_i (fetch_en_i),
    .inst_i     (inst_i),
    .pc_o       (pc_o),
    .id_pc_o    (id_pc),
    .id_inst_o  (id_inst),
    .id_valid_o (id_valid)
  );

  decode_stage u_decode (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .id_pc_i        (id_pc),
    .id_inst_i      (id_inst),
    .id_valid_i     (id_valid),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .wb_data_i      (wb_data_o),
    .ex_pc_o        (ex_pc),
    .ex_rs1_o       (ex_rs1),
    .ex_rs2_o       (ex_rs2),
    .ex_rdata1_o    (ex_rdata1),
    .ex_rdata2_o    (ex_rdata2),
    .ex_imm_o       (ex_imm),
    .ex_rd_o        (ex_rd),
    .ex_alu_op_o    (ex_alu_op),
    .ex_use_pc_o    (ex_use_pc),
    .ex_use_imm_o   (ex_use_imm),
    .ex_reg_write_o (ex_reg_write)
  );

  execute_stage u_execute (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .ex_pc_i        (ex_pc),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_rdata1_i    (ex_rdata1),
    .ex_rdata2_i    (ex_rdata2),
    .ex_imm_i       (ex_imm),
    .ex_rd_i        (ex_rd),
    .ex_alu_op_i    (ex_alu_op),
    .ex_use_pc_i    (ex_use_pc),
    .ex_use_imm_i   (ex_use_imm),
    .ex_reg_write_i (ex_reg_write),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .wb_data_i      (wb_data_o),
    .wb_reg_write_o (wb_reg_write),
    .wb_rd_o        (wb_rd),
    .wb_result_o    (wb_result)
  );

  writeback_stage u_writeback (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .reg_write_i (wb_reg_write),
    .rd_i        (wb_rd),
    .result_i    (wb_result),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .retired_o   (retired_o)
  );

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int INST_W     = 32;

  // addi x0, x0, 0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // ==========================================================================
  // opcodes and function fields
  // ==========================================================================
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 for the base ops, and the one selecting sub / sra
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

endpackage

`default_nettype wire

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
  import rv_pkg::*;
(
  input  wire                   clk,
  input  wire                   arst_n_i,
  input  wire                   reg_write_i,
  input  wire  [REG_ADDR_W-1:0] rd_i,
  input  wire  [XLEN-1:0]       result_i,
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o,
  output logic [XLEN-1:0]       retired_o
);

  // write-back port, also feeds the register file and forwarding
  assign wb_valid_o = reg_write_i;
  assign wb_rd_o    = rd_i;
  assign wb_data_o  = result_i;

  // retired instruction count, x0 writes included
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retired_o <= '0;
    end else if (wb_valid_o) begin
      retired_o <= retired_o + XLEN'(1);
    end
  end

  a_retired_monotonic : assert property (
    @(posedge clk) disable iff (!arst_n_i)
    retired_o >= $past(retired_o)
  ) else $error("retired_o decreased: %h -> %h", $past(retired_o), retired_o);

endmodule

`default_nettype wire
